// ==== hdl/lsu_bus_pkg.sv ====
// lsu bus package: data path widths and vector types for the load/store bus interface
package lsu_bus_pkg;

   localparam int BYTES_PER_WORD = 4;
   localparam int WORD_ADDR_LSB  = 2;   // first bit of the word index
   localparam int DW_ADDR_LSB    = 3;   // first bit of the doubleword index

   // ****************************************
   // vector types
   // ****************************************
   typedef logic [31:0] addr_t;                          // byte address
   typedef logic [31:0] word_t;                          // one data word
   typedef logic [63:0] dword_t;                         // hi lane : lo lane
   typedef logic [BYTES_PER_WORD-1:0]   byteen_t;        // byte enables of one word
   typedef logic [2*BYTES_PER_WORD-1:0] byteen_ext_t;    // byte enables over both lanes
   typedef logic [31:DW_ADDR_LSB]       dw_addr_t;       // doubleword index

endpackage

// ==== hdl/lsu_op_pkg.sv ====
// lsu op package: access sizes and pipeline stage counts of the load/store unit
package lsu_op_pkg;

   // access size as carried down the pipe, 2'b11 is not used
   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } access_size_e;

   // older stages searched by a dc2 load, dc3 first
   localparam int NUM_FWD_STAGES = 3;

endpackage

// ==== hdl/lsu_stage_if.sv ====
// lsu stage interface: the access fields held by one pipe stage
`timescale 1ns/10ps

interface lsu_stage_if;

   logic                     valid;
   logic                     load;
   logic                     store;
   logic                     busreq;       // access goes to the bus
   logic                     sideeffect;   // side-effect region, never forwarded
   lsu_bus_pkg::addr_t       addr;
   lsu_bus_pkg::addr_t       end_addr;     // last byte touched
   lsu_op_pkg::access_size_e size;
   lsu_bus_pkg::byteen_t     byteen;       // unshifted, bit 0 is the first byte
   logic                     dual;         // spills into the next word
   lsu_bus_pkg::word_t       store_data;

   modport src (
      output valid, load, store, busreq, sideeffect,
      output addr, end_addr, size, byteen, dual, store_data
   );

   modport dst (
      input valid, load, store, busreq, sideeffect,
      input addr, end_addr, size, byteen, dual, store_data
   );

endinterface

// ==== hdl/lsu_stage_pipe.sv ====
// lsu stage pipe: dc1 access decode and the dc2 to dc5 stage registers
`timescale 1ns/10ps

module lsu_stage_pipe (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid_dc1,
   input  logic                     load_dc1,
   input  logic                     store_dc1,
   input  lsu_op_pkg::access_size_e size_dc1,
   input  lsu_bus_pkg::addr_t       addr_dc1,
   input  lsu_bus_pkg::word_t       store_data_dc1,
   input  logic                     busreq_dc1,
   input  logic                     sideeffect_dc1,
   lsu_stage_if.src                 dc2,
   lsu_stage_if.src                 dc3,
   lsu_stage_if.src                 dc4,
   lsu_stage_if.src                 dc5
);

   lsu_bus_pkg::byteen_t byteen_dc1;
   lsu_bus_pkg::addr_t   end_addr_dc1;
   logic [1:0]           last_off;       // size in bytes minus one
   logic                 dual_dc1;

   // ****************************************
   // dc1 decode
   // ****************************************
   always_comb begin
      case (size_dc1)
         lsu_op_pkg::size_word: begin
            byteen_dc1 = 4'b1111;
            last_off   = 2'd3;
         end
         lsu_op_pkg::size_half: begin
            byteen_dc1 = 4'b0011;
            last_off   = 2'd1;
         end
         default: begin
            byteen_dc1 = 4'b0001;
            last_off   = 2'd0;
         end
      endcase
   end

   assign end_addr_dc1 = addr_dc1 + lsu_bus_pkg::addr_t'(last_off);
   // crossing into the other word of the doubleword
   assign dual_dc1 = addr_dc1[lsu_bus_pkg::WORD_ADDR_LSB] ^
                     end_addr_dc1[lsu_bus_pkg::WORD_ADDR_LSB];

   // ****************************************
   // stage registers
   // ****************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dc2.valid  <= 1'b0;
         dc3.valid  <= 1'b0;
         dc4.valid  <= 1'b0;
         dc5.valid  <= 1'b0;
         dc2.busreq <= 1'b0;
         dc3.busreq <= 1'b0;
         dc4.busreq <= 1'b0;
         dc5.busreq <= 1'b0;
      end else begin
         dc2.valid  <= valid_dc1;
         dc3.valid  <= dc2.valid;
         dc4.valid  <= dc3.valid;
         dc5.valid  <= dc4.valid;
         dc2.busreq <= busreq_dc1;
         dc3.busreq <= dc2.busreq;
         dc4.busreq <= dc3.busreq;
         dc5.busreq <= dc4.busreq;
      end
   end

   // payload only, qualified by valid and busreq downstream
   always_ff @(posedge clk) begin
      dc2.load       <= load_dc1;
      dc2.store      <= store_dc1;
      dc2.sideeffect <= sideeffect_dc1;
      dc2.addr       <= addr_dc1;
      dc2.end_addr   <= end_addr_dc1;
      dc2.size       <= size_dc1;
      dc2.byteen     <= byteen_dc1;
      dc2.dual       <= dual_dc1;
      dc2.store_data <= store_data_dc1;

      dc3.load       <= dc2.load;
      dc3.store      <= dc2.store;
      dc3.sideeffect <= dc2.sideeffect;
      dc3.addr       <= dc2.addr;
      dc3.end_addr   <= dc2.end_addr;
      dc3.size       <= dc2.size;
      dc3.byteen     <= dc2.byteen;
      dc3.dual       <= dc2.dual;
      dc3.store_data <= dc2.store_data;

      dc4.load       <= dc3.load;
      dc4.store      <= dc3.store;
      dc4.sideeffect <= dc3.sideeffect;
      dc4.addr       <= dc3.addr;
      dc4.end_addr   <= dc3.end_addr;
      dc4.size       <= dc3.size;
      dc4.byteen     <= dc3.byteen;
      dc4.dual       <= dc3.dual;
      dc4.store_data <= dc3.store_data;

      dc5.load       <= dc4.load;
      dc5.store      <= dc4.store;
      dc5.sideeffect <= dc4.sideeffect;
      dc5.addr       <= dc4.addr;
      dc5.end_addr   <= dc4.end_addr;
      dc5.size       <= dc4.size;
      dc5.byteen     <= dc4.byteen;
      dc5.dual       <= dc4.dual;
      dc5.store_data <= dc4.store_data;
   end

   // an access issued upstream is a load or a store, never both
   a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst_n)
      valid_dc1 |=> !(dc2.load && dc2.store));

endmodule

// ==== hdl/lsu_fwd_match.sv ====
// lsu forward match: per-byte hit of a dc2 load against one older store stage
`timescale 1ns/10ps

module lsu_fwd_match (
   lsu_stage_if.dst             ld,
   lsu_stage_if.dst             st,
   output lsu_bus_pkg::byteen_t byte_hit_lo,
   output lsu_bus_pkg::byteen_t byte_hit_hi,
   output lsu_bus_pkg::word_t   fwd_data_lo,
   output lsu_bus_pkg::word_t   fwd_data_hi
);

   localparam int WL = lsu_bus_pkg::WORD_ADDR_LSB;

   lsu_bus_pkg::byteen_ext_t ld_en_ext;
   lsu_bus_pkg::byteen_ext_t st_en_ext;
   lsu_bus_pkg::dword_t      st_data_ext;
   logic                     st_ok;
   logic                     ldlo_stlo, ldlo_sthi, ldhi_stlo, ldhi_sthi;

   // lane split, lo lane is the word of addr, hi lane the next one
   assign ld_en_ext   = {4'b0, ld.byteen} << ld.addr[1:0];
   assign st_en_ext   = {4'b0, st.byteen} << st.addr[1:0];
   assign st_data_ext = {32'b0, st.store_data} << {st.addr[1:0], 3'b000};

   assign st_ok = st.valid & st.store & ld.busreq;

   // word index compares, load lane first
   assign ldlo_stlo = st_ok & (ld.addr[31:WL] == st.addr[31:WL]);
   assign ldlo_sthi = st_ok & (ld.addr[31:WL] == st.end_addr[31:WL]);
   assign ldhi_stlo = st_ok & (ld.end_addr[31:WL] == st.addr[31:WL]);
   assign ldhi_sthi = st_ok & (ld.end_addr[31:WL] == st.end_addr[31:WL]);

   for (genvar i = 0; i < lsu_bus_pkg::BYTES_PER_WORD; i++) begin : g_byte
      localparam int HI = i + lsu_bus_pkg::BYTES_PER_WORD;
      logic lo_from_lo, lo_from_hi, hi_from_lo, hi_from_hi;

      assign lo_from_lo = ldlo_stlo & ld_en_ext[i]  & st_en_ext[i];
      assign lo_from_hi = ldlo_sthi & ld_en_ext[i]  & st_en_ext[HI];
      assign hi_from_lo = ldhi_stlo & ld_en_ext[HI] & st_en_ext[i];
      assign hi_from_hi = ldhi_sthi & ld_en_ext[HI] & st_en_ext[HI];

      assign byte_hit_lo[i] = lo_from_lo | lo_from_hi;
      assign byte_hit_hi[i] = hi_from_lo | hi_from_hi;

      assign fwd_data_lo[8*i +: 8] = lo_from_lo ? st_data_ext[8*i +: 8]  :
                                     lo_from_hi ? st_data_ext[8*HI +: 8] : 8'h00;
      assign fwd_data_hi[8*i +: 8] = hi_from_lo ? st_data_ext[8*i +: 8]  :
                                     hi_from_hi ? st_data_ext[8*HI +: 8] : 8'h00;
   end

endmodule

// ==== hdl/lsu_fwd_merge.sv ====
// lsu forward merge combining stage hits, deciding full hit and muxing dc3 read data
`timescale 1ns/10ps

module lsu_fwd_merge (
   input  logic                 clk,
   input  logic                 rst_n,
   lsu_stage_if.dst             ld,
   // index 0 is the youngest store in dc3
   input  lsu_bus_pkg::byteen_t hit_lo  [lsu_op_pkg::NUM_FWD_STAGES],
   input  lsu_bus_pkg::byteen_t hit_hi  [lsu_op_pkg::NUM_FWD_STAGES],
   input  lsu_bus_pkg::word_t   data_lo [lsu_op_pkg::NUM_FWD_STAGES],
   input  lsu_bus_pkg::word_t   data_hi [lsu_op_pkg::NUM_FWD_STAGES],
   input  lsu_bus_pkg::word_t   ld_bus_data_dc3,
   output lsu_bus_pkg::word_t   bus_read_data_dc3,
   output logic                 ld_full_hit_dc3
);

   localparam int BPW = lsu_bus_pkg::BYTES_PER_WORD;

   lsu_bus_pkg::byteen_ext_t ld_en_ext;
   lsu_bus_pkg::byteen_t     any_hit_lo;
   lsu_bus_pkg::byteen_t     any_hit_hi;
   lsu_bus_pkg::dword_t      fwd_pair;
   lsu_bus_pkg::word_t       fwd_data_dc2;
   lsu_bus_pkg::word_t       fwd_data_dc3;
   logic                     full_lo, full_hi;
   logic                     full_hit_dc2;

   // ****************************************
   // byte priority with the youngest store winning
   // ****************************************
   always_comb begin
      any_hit_lo = '0;
      any_hit_hi = '0;
      fwd_pair   = '0;
      // walk oldest to youngest so dc3 lands last
      for (int s = lsu_op_pkg::NUM_FWD_STAGES - 1; s >= 0; s--) begin
         for (int b = 0; b < BPW; b++) begin
            if (hit_lo[s][b])
               fwd_pair[8*b +: 8] = data_lo[s][8*b +: 8];
            if (hit_hi[s][b])
               fwd_pair[8*(b + BPW) +: 8] = data_hi[s][8*b +: 8];
         end
         any_hit_lo = any_hit_lo | hit_lo[s];
         any_hit_hi = any_hit_hi | hit_hi[s];
      end
   end

   assign ld_en_ext = {4'b0, ld.byteen} << ld.addr[1:0];

   // every enabled byte must be covered
   assign full_lo = &(any_hit_lo | ~ld_en_ext[BPW-1:0]);
   assign full_hi = &(any_hit_hi | ~ld_en_ext[2*BPW-1:BPW]);

   assign full_hit_dc2 = full_lo & full_hi & ld.valid & ld.load & ld.busreq & ~ld.sideeffect;

   // realign to the load's byte offset
   assign fwd_data_dc2 = lsu_bus_pkg::word_t'(fwd_pair >> {ld.addr[1:0], 3'b000});

   // ****************************************
   // dc3
   // ****************************************
   always_ff @(posedge clk) begin
      if (!rst_n)
         ld_full_hit_dc3 <= 1'b0;
      else
         ld_full_hit_dc3 <= full_hit_dc2;
   end

   always_ff @(posedge clk) begin
      fwd_data_dc3 <= fwd_data_dc2;
   end

   assign bus_read_data_dc3 = ld_full_hit_dc3 ? fwd_data_dc3 : ld_bus_data_dc3;

   // a full hit is built from forwarded bytes and never from an empty byte mask
   a_full_hit_fwd: assert property (@(posedge clk) disable iff (!rst_n)
      ld_full_hit_dc3 |-> $past(|{any_hit_hi, any_hit_lo}));

endmodule

// ==== hdl/lsu_coalesce_chk.sv ====
// lsu coalesce check: dc5 alignment and word/doubleword merge blockers
`timescale 1ns/10ps

module lsu_coalesce_chk (
   lsu_stage_if.dst dc2,
   lsu_stage_if.dst dc3,
   lsu_stage_if.dst dc4,
   lsu_stage_if.dst dc5,
   output logic     lsu_busreq_dc5,
   output logic     is_aligned_dc5,
   output logic     no_word_merge_dc5,
   output logic     no_dword_merge_dc5
);

   lsu_bus_pkg::addr_t   yng_addr;      // nearest younger bus request
   lsu_bus_pkg::dw_addr_t dw_dc5, dw_yng;
   logic                 yng_found, yng_load;
   logic                 dw_match, word_match;
   logic                 chk_dc5;

   assign lsu_busreq_dc5 = dc5.busreq;

   assign is_aligned_dc5 = ((dc5.size == lsu_op_pkg::size_word) & (dc5.addr[1:0] == 2'b00)) |
                           ((dc5.size == lsu_op_pkg::size_half) & ~dc5.addr[0]);

   // dc4 is closest to dc5
   always_comb begin
      yng_found = dc4.busreq | dc3.busreq | dc2.busreq;
      if (dc4.busreq) begin
         yng_load = dc4.load;
         yng_addr = dc4.addr;
      end else if (dc3.busreq) begin
         yng_load = dc3.load;
         yng_addr = dc3.addr;
      end else begin
         yng_load = dc2.load;
         yng_addr = dc2.addr;
      end
   end

   assign dw_dc5     = dc5.addr[31:lsu_bus_pkg::DW_ADDR_LSB];
   assign dw_yng     = yng_addr[31:lsu_bus_pkg::DW_ADDR_LSB];
   assign dw_match   = (dw_dc5 == dw_yng);
   assign word_match = dw_match & (dc5.addr[lsu_bus_pkg::WORD_ADDR_LSB] ==
                                   yng_addr[lsu_bus_pkg::WORD_ADDR_LSB]);

   assign chk_dc5 = dc5.busreq & ~dc5.dual & yng_found;

   assign no_word_merge_dc5  = chk_dc5 & (yng_load | ~word_match);
   assign no_dword_merge_dc5 = chk_dc5 & (yng_load | ~dw_match);

endmodule

// ==== hdl/lsu_bus_fwd.sv ====
// lsu bus forward top: store-to-load forwarding and coalescing checks of the lsu pipe
`timescale 1ns/10ps

module lsu_bus_fwd (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid_dc1,
   input  logic                     load_dc1,
   input  logic                     store_dc1,
   input  lsu_op_pkg::access_size_e size_dc1,
   input  lsu_bus_pkg::addr_t       addr_dc1,
   input  lsu_bus_pkg::word_t       store_data_dc1,
   input  logic                     busreq_dc1,
   input  logic                     sideeffect_dc1,
   input  lsu_bus_pkg::word_t       ld_bus_data_dc3,    // bus return data
   output lsu_bus_pkg::word_t       bus_read_data_dc3,
   output logic                     ld_full_hit_dc3,
   output logic                     lsu_busreq_dc5,
   output logic                     is_aligned_dc5,
   output logic                     no_word_merge_dc5,
   output logic                     no_dword_merge_dc5
);

   // per store stage lanes, 0 is dc3
   lsu_bus_pkg::byteen_t hit_lo  [lsu_op_pkg::NUM_FWD_STAGES];
   lsu_bus_pkg::byteen_t hit_hi  [lsu_op_pkg::NUM_FWD_STAGES];
   lsu_bus_pkg::word_t   data_lo [lsu_op_pkg::NUM_FWD_STAGES];
   lsu_bus_pkg::word_t   data_hi [lsu_op_pkg::NUM_FWD_STAGES];

   lsu_stage_if st_dc2 ();
   lsu_stage_if st_dc3 ();
   lsu_stage_if st_dc4 ();
   lsu_stage_if st_dc5 ();

   // ****************************************
   // pipe
   // ****************************************
   lsu_stage_pipe u_pipe (
      .clk            (clk),
      .rst_n          (rst_n),
      .valid_dc1      (valid_dc1),
      .load_dc1       (load_dc1),
      .store_dc1      (store_dc1),
      .size_dc1       (size_dc1),
      .addr_dc1       (addr_dc1),
      .store_data_dc1 (store_data_dc1),
      .busreq_dc1     (busreq_dc1),
      .sideeffect_dc1 (sideeffect_dc1),
      .dc2            (st_dc2),
      .dc3            (st_dc3),
      .dc4            (st_dc4),
      .dc5            (st_dc5)
   );

   // ****************************************
   // forwarding
   // ****************************************
   lsu_fwd_match u_match_dc3 (
      .ld (st_dc2), .st (st_dc3),
      .byte_hit_lo (hit_lo[0]), .byte_hit_hi (hit_hi[0]),
      .fwd_data_lo (data_lo[0]), .fwd_data_hi (data_hi[0])
   );

   lsu_fwd_match u_match_dc4 (
      .ld (st_dc2), .st (st_dc4),
      .byte_hit_lo (hit_lo[1]), .byte_hit_hi (hit_hi[1]),
      .fwd_data_lo (data_lo[1]), .fwd_data_hi (data_hi[1])
   );

   lsu_fwd_match u_match_dc5 (
      .ld (st_dc2), .st (st_dc5),
      .byte_hit_lo (hit_lo[2]), .byte_hit_hi (hit_hi[2]),
      .fwd_data_lo (data_lo[2]), .fwd_data_hi (data_hi[2])
   );

   lsu_fwd_merge u_merge (
      .clk               (clk),
      .rst_n             (rst_n),
      .ld                (st_dc2),
      .hit_lo            (hit_lo),
      .hit_hi            (hit_hi),
      .data_lo           (data_lo),
      .data_hi           (data_hi),
      .ld_bus_data_dc3   (ld_bus_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .ld_full_hit_dc3   (ld_full_hit_dc3)
   );

   lsu_coalesce_chk u_coalesce (
      .dc2                (st_dc2),
      .dc3                (st_dc3),
      .dc4                (st_dc4),
      .dc5                (st_dc5),
      .lsu_busreq_dc5     (lsu_busreq_dc5),
      .is_aligned_dc5     (is_aligned_dc5),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5)
   );

endmodule

// ==== sim/tb_lsu_bus_fwd.sv ====
// lsu bus forward testbench driving seeded random accesses against a byte-level reference model
`timescale 1ns/10ps

module tb_lsu_bus_fwd;

   localparam int NUM_ACCESSES   = 2000;
   localparam int RESET_CYCLES   = 5;
   localparam int DRAIN_CYCLES   = 4;                     // last access reaches dc5
   localparam int TIMEOUT_CYCLES = NUM_ACCESSES + 20;
   localparam logic [31:0] WIN_BASE = 32'h8000_1040;     // 32-byte window so hits are frequent

   logic                     clk;
   logic                     rst_n;
   logic                     valid_dc1, load_dc1, store_dc1;
   lsu_op_pkg::access_size_e size_dc1;
   lsu_bus_pkg::addr_t       addr_dc1;
   lsu_bus_pkg::word_t       store_data_dc1;
   logic                     busreq_dc1, sideeffect_dc1;
   lsu_bus_pkg::word_t       ld_bus_data_dc3;
   lsu_bus_pkg::word_t       bus_read_data_dc3;
   logic                     ld_full_hit_dc3, lsu_busreq_dc5, is_aligned_dc5;
   logic                     no_word_merge_dc5, no_dword_merge_dc5;

   integer seed;
   int     cycles;
   int     full_hits;

   // reference pipe indexed by stage number
   logic        m_valid [2:5];
   logic        m_load  [2:5];
   logic        m_store [2:5];
   logic        m_busreq [2:5];
   logic        m_side  [2:5];
   logic [1:0]  m_size  [2:5];
   logic [31:0] m_addr  [2:5];
   logic [31:0] m_data  [2:5];
   logic        exp_full;        // registered into dc3
   logic [31:0] exp_fwd;

   lsu_bus_fwd UUT (
      .clk                (clk),
      .rst_n              (rst_n),
      .valid_dc1          (valid_dc1),
      .load_dc1           (load_dc1),
      .store_dc1          (store_dc1),
      .size_dc1           (size_dc1),
      .addr_dc1           (addr_dc1),
      .store_data_dc1     (store_data_dc1),
      .busreq_dc1         (busreq_dc1),
      .sideeffect_dc1     (sideeffect_dc1),
      .ld_bus_data_dc3    (ld_bus_data_dc3),
      .bus_read_data_dc3  (bus_read_data_dc3),
      .ld_full_hit_dc3    (ld_full_hit_dc3),
      .lsu_busreq_dc5     (lsu_busreq_dc5),
      .is_aligned_dc5     (is_aligned_dc5),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failures found");
         $fatal(1, "timeout");
      end
   end

   // ****************************************
   // reference model
   // ****************************************
   function automatic int size_bytes(input logic [1:0] sz);
      if (sz == lsu_op_pkg::size_word)
         return 4;
      else if (sz == lsu_op_pkg::size_half)
         return 2;
      return 1;
   endfunction

   // each load byte takes the youngest valid store covering its address
   task automatic forward_model(output logic full, output logic [31:0] word);
      int          b;
      int          s;
      logic [31:0] a;
      logic [31:0] tmp;
      logic        hit;
      logic        all_hit;
      word    = '0;
      all_hit = 1'b1;
      for (b = 0; b < size_bytes(m_size[2]); b++) begin
         a   = m_addr[2] + b;
         hit = 1'b0;
         for (s = 3; s <= 5 && !hit; s++) begin
            if (m_valid[s] && m_store[s] && m_busreq[2] &&
                (a - m_addr[s]) < size_bytes(m_size[s])) begin
               tmp = m_data[s] >> (8 * (a - m_addr[s]));
               word[8*b +: 8] = tmp[7:0];
               hit = 1'b1;
            end
         end
         if (!hit)
            all_hit = 1'b0;
      end
      full = all_hit && m_valid[2] && m_load[2] && m_busreq[2] && !m_side[2];
   endtask

   // nearest younger bus request against a single-word dc5 request
   task automatic coalesce_model(output logic nwm, output logic ndm);
      int          s;
      int          y;
      logic [31:0] end5;
      nwm = 1'b0;
      ndm = 1'b0;
      y   = 0;
      for (s = 4; s >= 2 && y == 0; s--)
         if (m_busreq[s])
            y = s;
      end5 = m_addr[5] + size_bytes(m_size[5]) - 1;
      if (m_busreq[5] && (m_addr[5][2] == end5[2]) && y != 0) begin
         nwm = m_load[y] || (m_addr[y][31:2] != m_addr[5][31:2]);
         ndm = m_load[y] || (m_addr[y][31:3] != m_addr[5][31:3]);
      end
   endtask

   // one clock edge on the inputs the DUT just sampled
   task automatic advance_model();
      logic        full;
      logic [31:0] word;
      int          s;
      forward_model(full, word);
      exp_full = full && rst_n;
      exp_fwd  = word;
      for (s = 5; s > 2; s--) begin
         m_valid[s]  = m_valid[s-1];
         m_load[s]   = m_load[s-1];
         m_store[s]  = m_store[s-1];
         m_busreq[s] = m_busreq[s-1];
         m_side[s]   = m_side[s-1];
         m_size[s]   = m_size[s-1];
         m_addr[s]   = m_addr[s-1];
         m_data[s]   = m_data[s-1];
      end
      m_valid[2]  = valid_dc1;
      m_load[2]   = load_dc1;
      m_store[2]  = store_dc1;
      m_busreq[2] = busreq_dc1;
      m_side[2]   = sideeffect_dc1;
      m_size[2]   = size_dc1;
      m_addr[2]   = addr_dc1;
      m_data[2]   = store_data_dc1;
      if (!rst_n) begin
         for (s = 2; s <= 5; s++) begin
            m_valid[s]  = 1'b0;
            m_busreq[s] = 1'b0;
         end
      end
   endtask

   // ****************************************
   // stimulus and checks
   // ****************************************
   task automatic drive_access();
      integer     r;
      logic [1:0] sz;
      r  = $random(seed);
      sz = (r[8:7] == 2'b11) ? 2'b10 : r[8:7];
      valid_dc1      <= (r[3:0] != 4'h0);
      store_dc1      <= (r[6:4] < 3'd4);
      load_dc1       <= (r[6:4] >= 3'd4) && (r[6:4] != 3'd7);   // 7 is neither
      size_dc1       <= lsu_op_pkg::access_size_e'(sz);
      busreq_dc1     <= (r[12:9] != 4'h0);
      sideeffect_dc1 <= (r[15:13] == 3'b000);
      addr_dc1       <= WIN_BASE + 32'(r[20:16]);
      store_data_dc1 <= $random(seed);
   endtask

   task automatic drive_idle();
      valid_dc1      <= 1'b0;
      load_dc1       <= 1'b0;
      store_dc1      <= 1'b0;
      busreq_dc1     <= 1'b0;
      sideeffect_dc1 <= 1'b0;
   endtask

   task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Test failures found");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic check_outputs();
      logic nwm, ndm;
      logic aligned;
      coalesce_model(nwm, ndm);
      // naturally aligned multi-byte access
      aligned = (size_bytes(m_size[5]) > 1) && (m_addr[5] % size_bytes(m_size[5]) == 0);
      compare_value(32'(ld_full_hit_dc3), 32'(exp_full), "ld_full_hit_dc3");
      compare_value(bus_read_data_dc3, exp_full ? exp_fwd : ld_bus_data_dc3,
                    "bus_read_data_dc3");
      compare_value(32'(lsu_busreq_dc5), 32'(m_busreq[5]), "lsu_busreq_dc5");
      compare_value(32'(is_aligned_dc5), 32'(aligned), "is_aligned_dc5");
      compare_value(32'(no_word_merge_dc5), 32'(nwm), "no_word_merge_dc5");
      compare_value(32'(no_dword_merge_dc5), 32'(ndm), "no_dword_merge_dc5");
      if (exp_full)
         full_hits++;
   endtask

   initial begin
      int i;
      seed      = 85;
      cycles    = 0;
      full_hits = 0;
      clk       = 1'b0;
      rst_n     = 1'b0;
      valid_dc1 = 1'b0;
      load_dc1  = 1'b0;
      store_dc1 = 1'b0;
      size_dc1  = lsu_op_pkg::size_byte;
      addr_dc1  = '0;
      store_data_dc1  = '0;
      busreq_dc1      = 1'b0;
      sideeffect_dc1  = 1'b0;
      ld_bus_data_dc3 = '0;
      for (i = 2; i <= 5; i++) begin
         m_valid[i]  = 1'b0;
         m_busreq[i] = 1'b0;
      end
      exp_full = 1'b0;
      exp_fwd  = '0;

      for (i = 0; i < RESET_CYCLES + NUM_ACCESSES + DRAIN_CYCLES; i++) begin
         @(posedge clk);
         advance_model();
         rst_n <= (i >= RESET_CYCLES - 1);
         if (i >= RESET_CYCLES - 1 && i < RESET_CYCLES - 1 + NUM_ACCESSES)
            drive_access();
         else
            drive_idle();
         ld_bus_data_dc3 <= $random(seed);
         @(negedge clk);
         // payload of every stage is known from the last reset cycle on
         if (i >= RESET_CYCLES - 1)
            check_outputs();
      end

      if (full_hits == 0) begin
         $display("no load was ever fully forwarded from older stores");
         $display("Test failures found");
         $fatal(1, "no full hit");
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

endmodule

// ==== sources.f ====
hdl/lsu_bus_pkg.sv
hdl/lsu_op_pkg.sv
hdl/lsu_stage_if.sv
hdl/lsu_stage_pipe.sv
hdl/lsu_fwd_match.sv
hdl/lsu_fwd_merge.sv
hdl/lsu_coalesce_chk.sv
hdl/lsu_bus_fwd.sv
sim/tb_lsu_bus_fwd.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lsu bus forward testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f sources.f \
   --top-module tb_lsu_bus_fwd \
   -o tb_lsu_bus_fwd

./obj_dir/tb_lsu_bus_fwd
